//--- filelist.f
+incdir+rtl
rtl/irq_pkg.sv
rtl/irq_pop_if.sv
rtl/irq_level_fifo.sv
rtl/irq_queue_bank.sv
rtl/irq_cfg_regs.sv
rtl/irq_dispatch.sv
rtl/irq_ctrl_top.sv
tests/irq_clk_gen.sv
tests/irq_props.sv
tests/irq_tb.sv

//--- rtl/irq_cfg_regs.sv
`include "irq_settings.svh"

module irq_cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cfg_we,
    input  logic                     cfg_addr,
    input  irq_pkg::irq_cfg_word_u   cfg_data,
    output irq_pkg::irq_level_mask_t level_mask,
    output irq_pkg::irq_level_t      threshold
);

    logic wr_mask;
    logic wr_thresh;

    assign wr_mask   = cfg_we && (cfg_addr == `IRQ_CFG_ADDR_MASK);
    assign wr_thresh = cfg_we && (cfg_addr == `IRQ_CFG_ADDR_THRESH);

    // every level enabled out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_mask <= '1;
        end else if (wr_mask) begin
            level_mask <= cfg_data.mask;
        end
    end

    // threshold takes only the low bits of the data byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            threshold <= '0;
        end else if (wr_thresh) begin
            threshold <= cfg_data.thresh.level;
        end
    end

endmodule

//--- rtl/irq_ctrl_top.sv
`include "irq_settings.svh"

module irq_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic [15:0]            req_word,   // tag, level, device id
    output logic [`IRQ_LEVELS-1:0] req_credit, // one pulse per freed slot
    input  logic                   cfg_we,
    input  logic                   cfg_addr,
    input  logic [7:0]             cfg_data,
    input  logic                   out_credit, // consumer credit return
    output logic                   irq_valid,
    output logic [15:0]            irq_word
);

    irq_pkg::irq_level_mask_t level_mask;
    irq_pkg::irq_level_t      threshold;

    irq_pop_if pop_bus ();

    irq_queue_bank queue_bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_word   (req_word),
        .pop_port   (pop_bus.bank),
        .req_credit (req_credit)
    );

    irq_cfg_regs cfg_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .level_mask (level_mask),
        .threshold  (threshold)
    );

    irq_dispatch dispatch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop_port   (pop_bus.dispatch),
        .level_mask (level_mask),
        .threshold  (threshold),
        .out_credit (out_credit),
        .irq_valid  (irq_valid),
        .irq_word   (irq_word)
    );

endmodule

//--- rtl/irq_dispatch.sv
`include "irq_settings.svh"

module irq_dispatch (
    input  logic                     clk,
    input  logic                     rst_n,
    irq_pop_if.dispatch              pop_port,
    input  irq_pkg::irq_level_mask_t level_mask,
    input  irq_pkg::irq_level_t      threshold,
    input  logic                     out_credit,
    output logic                     irq_valid,
    output irq_pkg::irq_word_t       irq_word
);

    localparam int CRED_W = $clog2(`IRQ_OUT_CREDITS + 1);

    irq_pkg::irq_level_mask_t eligible;     // pending, enabled and above threshold
    irq_pkg::irq_level_t      sel_level;
    logic                     any_eligible;
    logic                     credit_avail;
    logic                     do_pop;
    logic [CRED_W-1:0]        credit_cnt;

    always_comb begin
        for (int i = 0; i < `IRQ_LEVELS; i++) begin
            eligible[i] = pop_port.pending[i]
                          && level_mask[i]
                          && (irq_pkg::irq_level_t'(i) >= threshold);
        end
    end

    // scan upward so the highest eligible level is the last one kept
    always_comb begin
        sel_level    = '0;
        any_eligible = 1'b0;
        for (int i = 0; i < `IRQ_LEVELS; i++) begin
            if (eligible[i]) begin
                sel_level    = irq_pkg::irq_level_t'(i);
                any_eligible = 1'b1;
            end
        end
    end

    assign credit_avail = (credit_cnt != '0);
    assign do_pop       = any_eligible && credit_avail; // stall when consumer is full

    assign pop_port.pop       = do_pop;
    assign pop_port.pop_level = sel_level;

    // issue credits, spent at pop time and returned by the consumer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= CRED_W'(`IRQ_OUT_CREDITS);
        end else begin
            case ({do_pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt; // spend and return net out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_valid <= 1'b0;
        end else begin
            irq_valid <= do_pop;
        end
    end

    // word held until the next issue
    always_ff @(posedge clk) begin
        if (do_pop) begin
            irq_word <= pop_port.pop_word;
        end
    end

endmodule

//--- rtl/irq_level_fifo.sv
`include "irq_settings.svh"

module irq_level_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  irq_pkg::irq_word_t push_word,
    input  logic               pop,
    output irq_pkg::irq_word_t head_word,
    output logic               not_empty
);

    localparam int PTR_W = $clog2(`IRQ_DEPTH);
    localparam int CNT_W = $clog2(`IRQ_DEPTH + 1);

    irq_pkg::irq_word_t mem [`IRQ_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // storage, written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`IRQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap at depth
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`IRQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle, or push and pop cancel
            endcase
        end
    end

    assign head_word = mem[rd_ptr]; // oldest entry
    assign not_empty = (count != '0);

endmodule

//--- rtl/irq_pkg.sv
`include "irq_settings.svh"

package irq_pkg;

    // one bit per priority level
    typedef logic [`IRQ_LEVELS-1:0] irq_level_mask_t;

    // priority level, higher value wins
    typedef logic [$clog2(`IRQ_LEVELS)-1:0] irq_level_t;

    // request word, priority sits just above the device id
    typedef struct packed {
        logic [7:0] tag;       // vector tag
        irq_level_t level;     // priority level
        logic [4:0] dev_id;    // requesting device
    } irq_word_t;

    // threshold view of the configuration word
    typedef struct packed {
        logic [4:0] unused;    // ignored on write
        irq_level_t level;     // lowest level allowed to issue
    } irq_thresh_view_t;

    // the configuration data byte means a mask or a threshold,
    // depending on which register is addressed
    typedef union packed {
        irq_level_mask_t  mask;
        irq_thresh_view_t thresh;
    } irq_cfg_word_u;

endpackage

//--- rtl/irq_pop_if.sv
interface irq_pop_if;

    irq_pkg::irq_level_mask_t pending;   // level queue non-empty flags
    logic                     pop;       // remove head of pop_level
    irq_pkg::irq_level_t      pop_level; // level selected by dispatcher
    irq_pkg::irq_word_t       pop_word;  // head word of pop_level, combinational

    // queue bank side
    modport bank (
        output pending,
        output pop_word,
        input  pop,
        input  pop_level
    );

    // dispatcher side
    modport dispatch (
        input  pending,
        input  pop_word,
        output pop,
        output pop_level
    );

endinterface

//--- rtl/irq_queue_bank.sv
`include "irq_settings.svh"

module irq_queue_bank (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  irq_pkg::irq_word_t       req_word,
    irq_pop_if.bank                  pop_port,
    output irq_pkg::irq_level_mask_t req_credit
);

    irq_pkg::irq_level_mask_t push_sel;   // push steered by level field
    irq_pkg::irq_level_mask_t pop_sel;    // pop steered by dispatcher level
    irq_pkg::irq_level_mask_t not_empty;
    irq_pkg::irq_word_t       head_words [`IRQ_LEVELS];

    for (genvar g = 0; g < `IRQ_LEVELS; g++) begin : g_level
        assign push_sel[g] = req_valid && (req_word.level == irq_pkg::irq_level_t'(g));
        assign pop_sel[g]  = pop_port.pop && (pop_port.pop_level == irq_pkg::irq_level_t'(g));

        irq_level_fifo level_fifo_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push_sel[g]),
            .push_word (req_word),
            .pop       (pop_sel[g]),
            .head_word (head_words[g]),
            .not_empty (not_empty[g])
        );
    end

    assign pop_port.pending  = not_empty;
    assign pop_port.pop_word = head_words[pop_port.pop_level]; // head of selected level

    // one slot freed per pop, hand the credit back a cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_credit <= '0;
        end else begin
            req_credit <= pop_sel;
        end
    end

endmodule

//--- rtl/irq_settings.svh
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// priority levels, level 7 is the most urgent
`define IRQ_LEVELS 8

// entries per level queue, also the producer credits per level after reset
`define IRQ_DEPTH 8

// issue credits the dispatcher owns after reset
`define IRQ_OUT_CREDITS 4

`define IRQ_CFG_ADDR_MASK   1'b0 // level enable mask register
`define IRQ_CFG_ADDR_THRESH 1'b1 // priority threshold register

`endif

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module irq_tb -f filelist.f \
    --Mdir obj_dir -o irq_sim

./obj_dir/irq_sim

//--- tests/irq_clk_gen.sv
module irq_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 2; // 4 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // held low over two rising edges, released just after the second
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- tests/irq_props.sv
`include "irq_settings.svh"

module irq_props (
    input logic                                   clk,
    input logic                                   rst_n,
    input irq_pkg::irq_level_mask_t               pending,
    input irq_pkg::irq_level_mask_t               level_mask,
    input irq_pkg::irq_level_t                    threshold,
    input logic                                   pop,
    input irq_pkg::irq_level_t                    pop_level,
    input logic                                   out_credit,
    input logic                                   irq_valid,
    input logic [$clog2(`IRQ_OUT_CREDITS + 1)-1:0] credit_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CRED_W = $clog2(`IRQ_OUT_CREDITS + 1);

    int unpaid; // words issued and not yet paid back by the consumer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            unpaid <= 0;
        end else begin
            unpaid <= unpaid + int'(irq_valid) - int'(out_credit);
        end
    end

    pop_eligible: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> pending[pop_level] && level_mask[pop_level] && (pop_level >= threshold))
        else $error("pop on a level that is empty, masked or below the threshold");

    // the credit for a word issued now was spent one cycle earlier
    // and a return in that same cycle did not count yet
    valid_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        irq_valid |-> (unpaid + int'($past(out_credit)) < `IRQ_OUT_CREDITS))
        else $error("word issued without an issue credit");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CRED_W'(`IRQ_OUT_CREDITS))
        else $error("issue credit count above its reset value");

endmodule

bind irq_dispatch irq_props props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .pending    (pop_port.pending),
    .level_mask (level_mask),
    .threshold  (threshold),
    .pop        (do_pop),
    .pop_level  (sel_level),
    .out_credit (out_credit),
    .irq_valid  (irq_valid),
    .credit_cnt (credit_cnt)
);

//--- tests/irq_tb.sv
`include "irq_settings.svh"

module irq_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int N_ROWS     = 43;
    localparam int LFSR_SEED  = 66815;
    localparam int WORD_WAIT  = 50; // cycles allowed for each expected word
    localparam int SETTLE     = 8;  // quiet cycles after a drain

    typedef enum logic [2:0] {
        OP_IDLE, OP_PUSH, OP_FILL, OP_CFG, OP_AUTO, OP_CREDIT, OP_DRAIN
    } op_e;

    typedef struct packed {
        op_e        op;
        logic [7:0] a;  // level, cycle count, credit count, address or on/off
        logic [7:0] b;  // word count or config data
    } row_t;

    logic                     clk;
    logic                     rst_n;
    logic                     req_valid;
    irq_pkg::irq_word_t       req_word;
    irq_pkg::irq_level_mask_t req_credit;
    logic                     cfg_we;
    logic                     cfg_addr;
    irq_pkg::irq_cfg_word_u   cfg_data;
    logic                     out_credit;
    logic                     irq_valid;
    irq_pkg::irq_word_t       irq_word;

    irq_pkg::irq_word_t       model_q [$]; // pending words in arrival order
    irq_pkg::irq_level_mask_t model_mask;
    irq_pkg::irq_level_t      model_thresh;
    int                       model_cred;  // issue credits the dispatcher should hold
    int                       pushes_made [`IRQ_LEVELS];
    int                       credits_asked;
    int                       n_checked;
    logic                     auto_credit; // consumer hands back a credit per word
    logic [15:0]              lfsr_state;

    irq_pkg::irq_word_t       issued_log [$]; // monitor side
    irq_pkg::irq_level_mask_t cred_log [$];
    int                       credits_back [`IRQ_LEVELS];
    int                       returns_due;

    row_t rows [N_ROWS] = '{
        '{OP_IDLE, 8'd8, 8'd0},   '{OP_CFG, 8'd0, 8'h00},
        '{OP_PUSH, 8'd3, 8'd2},   '{OP_PUSH, 8'd7, 8'd1},   '{OP_PUSH, 8'd0, 8'd2},
        '{OP_PUSH, 8'd5, 8'd2},   '{OP_PUSH, 8'd3, 8'd1},   '{OP_PUSH, 8'd7, 8'd2},
        '{OP_CFG, 8'd0, 8'hff},   '{OP_DRAIN, 8'd0, 8'd0},  '{OP_CFG, 8'd0, 8'h00},
        '{OP_PUSH, 8'd1, 8'd2},   '{OP_PUSH, 8'd6, 8'd2},   '{OP_PUSH, 8'd4, 8'd2},
        '{OP_PUSH, 8'd2, 8'd1},   '{OP_PUSH, 8'd7, 8'd1},   '{OP_CFG, 8'd1, 8'h04},
        '{OP_CFG, 8'd0, 8'hbf},   '{OP_DRAIN, 8'd0, 8'd0},  '{OP_CFG, 8'd1, 8'h00},
        '{OP_DRAIN, 8'd0, 8'd0},  '{OP_CFG, 8'd0, 8'hff},   '{OP_DRAIN, 8'd0, 8'd0},
        '{OP_AUTO, 8'd0, 8'd0},   '{OP_CFG, 8'd0, 8'h00},   '{OP_PUSH, 8'd2, 8'd3},
        '{OP_PUSH, 8'd5, 8'd3},   '{OP_CFG, 8'd0, 8'hff},   '{OP_DRAIN, 8'd0, 8'd0},
        '{OP_CREDIT, 8'd1, 8'd0}, '{OP_DRAIN, 8'd0, 8'd0},  '{OP_AUTO, 8'd1, 8'd0},
        '{OP_CREDIT, 8'd4, 8'd0}, '{OP_DRAIN, 8'd0, 8'd0},  '{OP_CFG, 8'd0, 8'h00},
        '{OP_FILL, 8'd0, 8'd0},   '{OP_CFG, 8'd0, 8'hff},   '{OP_DRAIN, 8'd0, 8'd0},
        '{OP_CFG, 8'd0, 8'h00},   '{OP_FILL, 8'd0, 8'd0},   '{OP_CFG, 8'd0, 8'hff},
        '{OP_DRAIN, 8'd0, 8'd0},  '{OP_IDLE, 8'd8, 8'd0}
    };

    irq_clk_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    irq_ctrl_top irq_ctrl_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_word   (req_word),
        .req_credit (req_credit),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .out_credit (out_credit),
        .irq_valid  (irq_valid),
        .irq_word   (irq_word)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input irq_pkg::irq_word_t got,
                              input irq_pkg::irq_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] time %0d ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_credits(input string name, input irq_pkg::irq_level_mask_t got,
                                 input irq_pkg::irq_level_mask_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] time %0d ns: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[14:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int level_count(input int lvl);
        int n;
        n = 0;
        foreach (model_q[i]) begin
            if (int'(model_q[i].level) == lvl) n++;
        end
        return n;
    endfunction

    function automatic int producer_credits(input int lvl);
        return `IRQ_DEPTH - pushes_made[lvl] + credits_back[lvl];
    endfunction

    // highest level that is pending, enabled and at or above the threshold
    function automatic int pick_level();
        int best;
        best = -1;
        foreach (model_q[i]) begin
            if (model_mask[model_q[i].level] && (model_q[i].level >= model_thresh)
                    && (int'(model_q[i].level) > best)) begin
                best = int'(model_q[i].level);
            end
        end
        return best;
    endfunction

    function automatic irq_pkg::irq_word_t take_word(input int lvl);
        irq_pkg::irq_word_t w;
        w = '0;
        foreach (model_q[i]) begin
            if (int'(model_q[i].level) == lvl) begin
                w = model_q[i];
                model_q.delete(i);
                break; // oldest of the level
            end
        end
        return w;
    endfunction

    function automatic irq_pkg::irq_level_mask_t level_bit(input int lvl);
        irq_pkg::irq_level_mask_t m;
        m = '0;
        m[lvl] = 1'b1;
        return m;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        cfg_we    = 1'b0;
    endtask

    task automatic push_word(input int lvl);
        irq_pkg::irq_word_t w;
        logic [15:0]        bits;
        bits     = take_bits(8);
        w.tag    = bits[7:0];
        bits     = take_bits(5);
        w.dev_id = bits[4:0];
        w.level  = irq_pkg::irq_level_t'(lvl);
        if (producer_credits(lvl) <= 0) begin
            abort_run($sformatf("producer has no credit left for level %0d", lvl));
        end
        pushes_made[lvl]++;
        model_q.push_back(w);
        step();
        req_valid = 1'b1;
        req_word  = w;
    endtask

    task automatic check_totals();
        irq_pkg::irq_level_mask_t agree;
        agree = '0;
        for (int l = 0; l < `IRQ_LEVELS; l++) begin
            agree[l] = (producer_credits(l) == `IRQ_DEPTH - level_count(l));
        end
        check_credits("producer credit totals", agree, '1);
    endtask

    task automatic drain_and_check();
        irq_pkg::irq_word_t exp;
        int                 lvl;
        int                 waited;
        lvl = pick_level();
        while (lvl >= 0 && model_cred > 0) begin
            exp = take_word(lvl);
            if (!auto_credit) model_cred--;
            waited = 0;
            while (issued_log.size() <= n_checked) begin
                @(posedge clk);
                waited++;
                if (waited > WORD_WAIT) abort_run("an expected word was never issued");
            end
            check_word("irq_word", issued_log[n_checked], exp);
            check_credits("req_credit", cred_log[n_checked], level_bit(lvl));
            n_checked++;
            lvl = pick_level();
        end
        repeat (SETTLE) @(posedge clk);
        if (issued_log.size() != n_checked) begin
            abort_run("a word issued that was not eligible or had no issue credit");
        end
        check_totals();
    endtask

    task automatic apply_row(input row_t row);
        irq_pkg::irq_cfg_word_u cw;
        case (row.op)
            OP_IDLE: begin
                repeat (row.a) step();
                if (issued_log.size() != n_checked) abort_run("a word issued while idle");
            end
            OP_PUSH: begin
                repeat (row.b) push_word(int'(row.a));
            end
            OP_FILL: begin
                for (int rep = 0; rep < `IRQ_DEPTH; rep++) begin
                    for (int l = 0; l < `IRQ_LEVELS; l++) begin
                        push_word(l);
                    end
                end
            end
            OP_CFG: begin
                cw = row.b;
                if (row.a[0] == `IRQ_CFG_ADDR_THRESH) model_thresh = cw.thresh.level;
                else model_mask = cw.mask;
                step();
                cfg_we   = 1'b1;
                cfg_addr = row.a[0];
                cfg_data = cw;
            end
            OP_AUTO:   auto_credit = row.a[0];
            OP_CREDIT: begin
                credits_asked += int'(row.a);
                model_cred    += int'(row.a);
            end
            OP_DRAIN:  drain_and_check();
            default:   abort_run("unknown operation in the stimulus table");
        endcase
    endtask

    // outputs sampled mid-cycle, well clear of the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            for (int l = 0; l < `IRQ_LEVELS; l++) begin
                if (req_credit[l]) credits_back[l]++;
            end
            if (irq_valid) begin
                issued_log.push_back(irq_word);
                cred_log.push_back(req_credit);
                if (auto_credit) returns_due++;
            end else begin
                check_credits("req_credit", req_credit, '0);
            end
        end
    end

    // consumer side, one out_credit pulse per owed credit
    initial begin
        int sent;
        sent       = 0;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (credits_asked + returns_due > sent) begin
                out_credit = 1'b1;
                sent++;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        #(N_ROWS * 40 * CLK_PERIOD);
        abort_run("watchdog expired before the stimulus table finished");
    end

    initial begin
        req_valid     = 1'b0;
        req_word      = '0;
        cfg_we        = 1'b0;
        cfg_addr      = 1'b0;
        cfg_data      = '0;
        model_mask    = '1; // reset state of the configuration block
        model_thresh  = '0;
        model_cred    = `IRQ_OUT_CREDITS;
        credits_asked = 0;
        n_checked     = 0;
        auto_credit   = 1'b1;
        lfsr_state    = 16'(LFSR_SEED);
        foreach (pushes_made[l]) pushes_made[l] = 0;
        @(posedge rst_n);
        for (int r = 0; r < N_ROWS; r++) begin
            apply_row(rows[r]);
            step();
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule
